/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := cache_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
+incdir+verilog
verilog/cache_pkg.sv
verilog/cache_arrays.sv
verilog/plru_tree.sv
verilog/cache_stage_1.sv
verilog/cache_stage_2.sv
verilog/cache_top.sv
tb/mem_model.sv
tb/cache_tb.sv

/* tb/cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_params.svh"

module cache_tb;

    localparam int DRIVE_DLY = 5;
    localparam int RESP_TIMEOUT = 200;

    typedef struct packed {
        logic        is_load;
        logic [31:0] addr;
        logic [31:0] data;
    } expect_t;

    logic                       clk, rst;
    logic [31:0]                ufp_addr, ufp_wdata, ufp_rdata;
    logic [3:0]                 ufp_rmask, ufp_wmask;
    logic                       ufp_resp;
    logic [31:0]                dfp_addr;
    logic                       dfp_read, dfp_write, dfp_resp;
    logic [`LINE_BYTES*8-1:0]   dfp_wdata, dfp_rdata;
    logic [31:0]                wr_count, last_wr_addr;
    logic [`LINE_BYTES*8-1:0]   last_wr_line;

    logic [7:0] shadow_mem [logic [31:0]];
    expect_t    pending_q [$];
    expect_t    done_entry;
    int         seed;

    cache_top dut0 (
        .clk, .rst,
        .ufp_addr, .ufp_rmask, .ufp_wmask, .ufp_wdata, .ufp_rdata, .ufp_resp,
        .dfp_addr, .dfp_read, .dfp_write, .dfp_wdata, .dfp_rdata, .dfp_resp
    );

    mem_model mem0 (
        .clk, .rst,
        .dfp_addr, .dfp_read, .dfp_write, .dfp_wdata, .dfp_rdata, .dfp_resp,
        .wr_count, .last_wr_addr, .last_wr_line
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] memory_init_word(input logic [31:0] a);
        return {a[7:0], a[15:8], a[23:16], a[31:24]} ^ 32'h6b3c_91d5;
    endfunction

    // bytes never stored still hold the memory's initial pattern
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] base;
        logic [31:0] word;
        base = {addr[31:2], 2'b00};
        word = memory_init_word(base);
        for (int i = 0; i < 4; i++) begin
            if (shadow_mem.exists(base + 32'(i))) begin
                word[8*i +: 8] = shadow_mem[base + 32'(i)];
            end
        end
        return word;
    endfunction

    function automatic logic [`LINE_BYTES*8-1:0] expected_line(input logic [31:0] line_addr);
        logic [`LINE_BYTES*8-1:0] line;
        for (int w = 0; w < `LINE_BYTES/4; w++) begin
            line[32*w +: 32] = expected_word(line_addr + 32'(4*w));
        end
        return line;
    endfunction

    function automatic logic [31:0] make_addr(input logic [`TAG_W-1:0] tag,
                                              input logic [`SET_W-1:0] set_no,
                                              input logic [2:0] word);
        return {tag, set_no, word, 2'b00};
    endfunction

    task automatic apply_store(input logic [31:0] addr, input logic [3:0] wmask,
                               input logic [31:0] wdata);
        for (int i = 0; i < 4; i++) begin
            if (wmask[i]) begin
                shadow_mem[{addr[31:2], 2'b00} + 32'(i)] = wdata[8*i +: 8];
            end
        end
    endtask

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(input logic [255:0] got, input logic [255:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("Error at %0t: %s, got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // returns the number of cycles from the request to the response
    task automatic do_access(input logic [31:0] addr, input logic [3:0] rmask,
                             input logic [3:0] wmask, input logic [31:0] wdata,
                             output int cycles);
        expect_t entry;
        if (|wmask) begin
            apply_store(addr, wmask, wdata);
        end
        entry.is_load = |rmask;
        entry.addr = addr;
        entry.data = expected_word(addr);
        pending_q.push_back(entry);
        ufp_addr = addr;
        ufp_rmask = rmask;
        ufp_wmask = wmask;
        ufp_wdata = wdata;
        cycles = 0;
        do begin
            @(posedge clk);
            #DRIVE_DLY;
            cycles++;
            if (cycles > RESP_TIMEOUT) begin
                $display("Timeout at %0t: no ufp_resp for address %h", $time, addr);
                abort_run();
            end
        end while (!ufp_resp);
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            check_value(256'(dfp_read && dfp_write), 256'd0, "dfp read and write both high");
            if (dfp_read || dfp_write) begin
                check_value(256'(dfp_addr[`OFFSET_W-1:0]), 256'd0, "dfp address alignment");
            end
            if (ufp_resp) begin
                if (pending_q.size() == 0) begin
                    $display("Unexpected ufp_resp at %0t with no request outstanding", $time);
                    abort_run();
                end else begin
                    done_entry = pending_q.pop_front();
                    if (done_entry.is_load) begin
                        check_value(256'(ufp_rdata), 256'(done_entry.data),
                                    $sformatf("load from %h", done_entry.addr));
                    end
                end
            end
        end
    end

    initial begin
        int          cycles;
        logic [31:0] a, r, wdata, wr_before;
        logic [3:0]  m;
        seed = 98334;
        clk = 1'b0;
        rst = 1'b1;
        ufp_addr = '0;
        ufp_rmask = '0;
        ufp_wmask = '0;
        ufp_wdata = '0;
        repeat (4) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        check_value(256'({ufp_resp, dfp_read, dfp_write}), 256'd0, "outputs after reset");

        for (int k = 0; k < 4; k++) begin
            a = make_addr(23'h100 + 23'(k), 4'd1 + 4'(k), 3'(k));
            do_access(a, 4'hf, 4'h0, 32'h0, cycles); // fresh line misses
            do_access(a, 4'hf, 4'h0, 32'h0, cycles);
            check_value(256'(cycles), 256'd1, "repeat read hit latency");
        end

        a = make_addr(23'h200, 4'd2, 3'd3);
        do_access(a, 4'h0, 4'b0001, 32'h1122_3344, cycles);
        do_access(a, 4'h0, 4'b0110, 32'haabb_ccdd, cycles);
        do_access(a, 4'hf, 4'h0, 32'h0, cycles);
        check_value(256'(cycles), 256'd2, "load after store hit stall");
        do_access(a, 4'h0, 4'b1000, 32'h5500_0000, cycles);
        do_access(a + 32'd4, 4'h0, 4'b0011, 32'h0000_beef, cycles);
        do_access(a + 32'd4, 4'h0, 4'b1100, 32'hcafe_0000, cycles);
        do_access(a, 4'hf, 4'h0, 32'h0, cycles);
        do_access(a + 32'd4, 4'hf, 4'h0, 32'h0, cycles);
        do_access(a - 32'd4, 4'hf, 4'h0, 32'h0, cycles);

        do_access(make_addr(23'h200, 4'd2, 3'd0), 4'hf, 4'h0, 32'h0, cycles);
        for (int w = 0; w < 8; w++) begin
            do_access(make_addr(23'h200, 4'd2, 3'(w)), 4'hf, 4'h0, 32'h0, cycles);
            check_value(256'(cycles), 256'd1, "back-to-back read hit spacing");
        end

        wr_before = wr_count;
        for (int k = 0; k < 4; k++) begin
            wdata = $random(seed);
            do_access(make_addr(23'h300 + 23'(k), 4'd5, 3'(k)), 4'h0, 4'hf, wdata, cycles);
        end
        check_value(256'(wr_count), 256'(wr_before), "writeback before the set was full");
        wdata = $random(seed);
        do_access(make_addr(23'h304, 4'd5, 3'd4), 4'h0, 4'hf, wdata, cycles);
        check_value(256'(wr_count), 256'(wr_before + 32'd1), "writeback count on eviction");
        // the first line filled is the least recently used one
        check_value(256'(last_wr_addr), 256'(make_addr(23'h300, 4'd5, 3'd0)),
                    "writeback address");
        check_value(last_wr_line, expected_line(make_addr(23'h300, 4'd5, 3'd0)),
                    "writeback line data");
        for (int k = 0; k < 5; k++) begin
            do_access(make_addr(23'h300 + 23'(k), 4'd5, 3'(k)), 4'hf, 4'h0, 32'h0, cycles);
        end

        // eight tags over four sets keeps evicting dirty lines
        for (int n = 0; n < 200; n++) begin
            r = $random(seed);
            a = make_addr(23'h400 + 23'(r[2:0]), 4'd8 + 4'(r[4:3]), r[7:5]);
            if (r[8]) begin
                m = r[12:9];
                if (m == 4'h0) begin
                    m = 4'hf;
                end
                wdata = $random(seed);
                do_access(a, 4'h0, m, wdata, cycles);
            end else begin
                do_access(a, 4'hf, 4'h0, 32'h0, cycles);
            end
        end

        ufp_rmask = '0;
        ufp_wmask = '0;
        repeat (3) @(posedge clk);
        if (pending_q.size() == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Error at %0t: %0d responses never arrived", $time, pending_q.size());
            abort_run();
        end
    end

endmodule : cache_tb

`default_nettype wire

/* tb/mem_model.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_params.svh"

module mem_model #(
    parameter int RESP_DELAY = 3
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [31:0]                 dfp_addr,
    input  logic                        dfp_read,
    input  logic                        dfp_write,
    input  logic [`LINE_BYTES*8-1:0]    dfp_wdata,
    output logic [`LINE_BYTES*8-1:0]    dfp_rdata,
    output logic                        dfp_resp,
    output logic [31:0]                 wr_count,
    output logic [31:0]                 last_wr_addr,
    output logic [`LINE_BYTES*8-1:0]    last_wr_line
);

    logic [`LINE_BYTES*8-1:0] lines [logic [31:0]]; // only lines written back are stored
    logic [31:0]              line_key;
    int                       wait_cnt;

    assign line_key = {dfp_addr[31:`OFFSET_W], `OFFSET_W'(0)};

    // untouched memory holds each word address byte swapped and xored with a constant
    function automatic logic [31:0] initial_word(input logic [31:0] a);
        return {a[7:0], a[15:8], a[23:16], a[31:24]} ^ 32'h6b3c_91d5;
    endfunction

    function automatic logic [`LINE_BYTES*8-1:0] line_contents(input logic [31:0] key);
        logic [`LINE_BYTES*8-1:0] line;
        if (lines.exists(key)) begin
            line = lines[key];
        end else begin
            for (int w = 0; w < `LINE_BYTES/4; w++) begin
                line[32*w +: 32] = initial_word(key + 32'(4*w));
            end
        end
        return line;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            dfp_resp <= 1'b0;
            dfp_rdata <= '0;
            wait_cnt <= 0;
            wr_count <= '0;
            last_wr_addr <= '0;
            last_wr_line <= '0;
        end else if (dfp_resp) begin
            dfp_resp <= 1'b0; // the cache drops read or write after the response cycle
            wait_cnt <= 0;
        end else if (dfp_read || dfp_write) begin
            if (wait_cnt == RESP_DELAY - 1) begin
                dfp_resp <= 1'b1;
                wait_cnt <= 0;
                if (dfp_write) begin
                    lines[line_key] = dfp_wdata;
                    wr_count <= wr_count + 32'd1;
                    last_wr_addr <= dfp_addr;
                    last_wr_line <= dfp_wdata;
                end else begin
                    dfp_rdata <= line_contents(line_key);
                end
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end
    end

endmodule : mem_model

`default_nettype wire

/* verilog/cache_arrays.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_params.svh"

module cache_arrays import cache_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`SET_W-1:0]           rd_set,
    input  logic [`SET_W-1:0]           wr_set,
    input  logic [`CACHE_WAYS-1:0]      web,
    input  logic [`CACHE_WAYS-1:0]      valid_in,
    input  line_u                       data_in [`CACHE_WAYS],
    input  tag_entry_t                  tag_in [`CACHE_WAYS],
    input  logic [`LINE_BYTES-1:0]      data_array_wmask,
    output line_u                       data_out [`CACHE_WAYS],
    output tag_entry_t                  tag_out [`CACHE_WAYS],
    output logic [`CACHE_WAYS-1:0]      valid_out
);

    line_u                  data_mem  [`CACHE_WAYS][`CACHE_SETS];
    tag_entry_t             tag_mem   [`CACHE_WAYS][`CACHE_SETS];
    logic [`CACHE_SETS-1:0] valid_mem [`CACHE_WAYS];

    // read returns the old contents when the same set is written in the same cycle
    always_ff @(posedge clk) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (!web[w]) begin
                for (int b = 0; b < `LINE_BYTES; b++) begin
                    if (data_array_wmask[b]) begin
                        data_mem[w][wr_set].flat[8*b +: 8] <= data_in[w].flat[8*b +: 8];
                    end
                end
                tag_mem[w][wr_set] <= tag_in[w];
            end
            data_out[w] <= data_mem[w][rd_set];
            tag_out[w] <= tag_mem[w][rd_set];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                valid_mem[w] <= '0;
            end
            valid_out <= '0;
        end else begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (!web[w]) begin
                    valid_mem[w][wr_set] <= valid_in[w];
                end
                valid_out[w] <= valid_mem[w][rd_set];
            end
        end
    end

endmodule : cache_arrays

`default_nettype wire

/* verilog/cache_params.svh */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// four ways is fixed by the three-bit tree LRU
`define CACHE_WAYS  4
`define CACHE_SETS  16
`define LINE_BYTES  32

// address split is tag | set | byte offset
`define TAG_W       23
`define SET_W       4
`define OFFSET_W    5

`endif

/* verilog/cache_pkg.sv */
`default_nettype none
`include "cache_params.svh"

package cache_pkg;

    // request as held between stage one and stage two
    typedef struct packed {
        logic [31:0]            addr;
        logic [`TAG_W-1:0]      tag;
        logic [`SET_W-1:0]      set_no;
        logic [`OFFSET_W-1:0]   offset;
        logic [3:0]             rmask;
        logic [3:0]             wmask;
        logic [31:0]            wdata;
    } stage_reg_t;

    typedef struct packed {
        logic                   dirty;
        logic [`TAG_W-1:0]      tag;
    } tag_entry_t;

    // flat view for dfp traffic, word view for the hit mux
    typedef union packed {
        logic [`LINE_BYTES*8-1:0]           flat;
        logic [`LINE_BYTES/4-1:0][31:0]     words;
    } line_u;

endpackage : cache_pkg

`default_nettype wire

/* verilog/cache_stage_1.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_params.svh"

module cache_stage_1 import cache_pkg::*; (
    input  logic [31:0]                 ufp_addr,
    input  logic [3:0]                  ufp_rmask,
    input  logic [3:0]                  ufp_wmask,
    input  logic [31:0]                 ufp_wdata,
    input  logic [`LINE_BYTES*8-1:0]    dfp_rdata,
    input  logic                        dfp_resp,
    input  logic                        read_halt,
    input  logic                        write_halt,
    input  logic                        dirty_halt,
    input  logic [2:0]                  lru_read,
    input  logic [1:0]                  hit_way,
    input  logic                        write_done_reg,
    input  stage_reg_t                  stage_reg,
    output stage_reg_t                  stage_reg_next,
    output logic                        write_done,
    output logic [`CACHE_WAYS-1:0]      web,
    output logic [`CACHE_WAYS-1:0]      valid_in,
    output line_u                       data_in [`CACHE_WAYS],
    output tag_entry_t                  tag_in [`CACHE_WAYS],
    output logic [`LINE_BYTES-1:0]      data_array_wmask,
    output logic [1:0]                  victim_way
);

    logic hold;

    // the array read for a request that follows a store is stale, so keep it one more cycle
    assign hold = read_halt || (write_done_reg && (|stage_reg.rmask || |stage_reg.wmask));

    always_comb begin
        if (lru_read[0]) begin
            victim_way = lru_read[1] ? 2'd0 : 2'd1;
        end else begin
            victim_way = lru_read[2] ? 2'd2 : 2'd3;
        end
    end

    always_comb begin
        web = '1; // web is active low so nothing is written by default
        valid_in = '0;
        data_array_wmask = '1;
        write_done = 1'b0;
        for (int i = 0; i < `CACHE_WAYS; i++) begin
            data_in[i] = '0;
            tag_in[i] = '0;
        end

        if (write_halt) begin
            web[hit_way] = 1'b0;
            data_in[hit_way].flat[{stage_reg.offset, 3'b000} +: 32] = stage_reg.wdata;
            tag_in[hit_way] = '{dirty: 1'b1, tag: stage_reg.tag};
            valid_in[hit_way] = 1'b1;
            data_array_wmask = '0;
            data_array_wmask[stage_reg.offset +: 4] = stage_reg.wmask; // only the stored bytes
            write_done = 1'b1;
        end else if (read_halt && dfp_resp && !dirty_halt) begin
            web[victim_way] = 1'b0; // refill lands on the fetch response
            data_in[victim_way].flat = dfp_rdata;
            tag_in[victim_way] = '{dirty: 1'b0, tag: stage_reg.tag};
            valid_in[victim_way] = 1'b1;
        end
    end

    always_comb begin
        stage_reg_next = stage_reg;
        if (!hold) begin
            stage_reg_next.addr = ufp_addr;
            stage_reg_next.tag = ufp_addr[31 -: `TAG_W];
            stage_reg_next.set_no = ufp_addr[`OFFSET_W +: `SET_W];
            stage_reg_next.offset = ufp_addr[`OFFSET_W-1:0];
            stage_reg_next.rmask = ufp_rmask;
            stage_reg_next.wmask = ufp_wmask;
            stage_reg_next.wdata = ufp_wdata;
        end
    end

endmodule : cache_stage_1

`default_nettype wire

/* verilog/cache_stage_2.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_params.svh"

module cache_stage_2 import cache_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  stage_reg_t                  stage_reg,
    input  line_u                       data_out [`CACHE_WAYS],
    input  tag_entry_t                  tag_out [`CACHE_WAYS],
    input  logic [`CACHE_WAYS-1:0]      valid_out,
    input  logic [1:0]                  victim_way,
    input  logic                        write_done,
    output logic [31:0]                 ufp_rdata,
    output logic                        ufp_resp,
    output logic [31:0]                 dfp_addr,
    output logic                        dfp_read,
    output logic                        dfp_write,
    output logic [`LINE_BYTES*8-1:0]    dfp_wdata,
    input  logic                        dfp_resp,
    output logic                        read_halt,
    output logic                        write_halt,
    output logic                        dirty_halt,
    output logic                        write_done_reg,
    output logic [1:0]                  hit_way,
    output logic                        lru_touch
);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_WB     = 2'd1;
    localparam logic [1:0] ST_FETCH  = 2'd2;
    localparam logic [1:0] ST_REREAD = 2'd3;

    logic [1:0]             state, state_next;
    logic [`CACHE_WAYS-1:0] hit_vec;
    logic                   lookup, hit, miss, victim_dirty;

    always_comb begin
        hit_vec = '0;
        hit_way = '0;
        for (int i = 0; i < `CACHE_WAYS; i++) begin
            hit_vec[i] = valid_out[i] && (tag_out[i].tag == stage_reg.tag);
            if (hit_vec[i]) begin
                hit_way = 2'(i);
            end
        end
    end

    // no lookup while the arrays still show data from before the last write
    assign lookup = (|stage_reg.rmask || |stage_reg.wmask) && state == ST_IDLE && !write_done_reg;
    assign hit = lookup && |hit_vec;
    assign miss = lookup && !(|hit_vec);
    assign victim_dirty = valid_out[victim_way] && tag_out[victim_way].dirty;

    assign ufp_resp = hit;
    assign ufp_rdata = data_out[hit_way].words[stage_reg.offset[`OFFSET_W-1:2]];
    assign write_halt = hit && |stage_reg.wmask;
    assign read_halt = miss || state != ST_IDLE;
    assign dirty_halt = state == ST_WB;
    assign lru_touch = hit || (state == ST_FETCH && dfp_resp);

    assign dfp_write = state == ST_WB;
    assign dfp_read = state == ST_FETCH;
    assign dfp_wdata = data_out[victim_way].flat;
    assign dfp_addr = dfp_write ? {tag_out[victim_way].tag, stage_reg.set_no, `OFFSET_W'(0)}
                                : {stage_reg.addr[31:`OFFSET_W], `OFFSET_W'(0)};

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (miss) begin
                    state_next = victim_dirty ? ST_WB : ST_FETCH;
                end
            end
            ST_WB: begin
                if (dfp_resp) begin
                    state_next = ST_FETCH;
                end
            end
            ST_FETCH: begin
                if (dfp_resp) begin
                    state_next = ST_REREAD; // refill is written this cycle
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            write_done_reg <= 1'b0;
        end else begin
            state <= state_next;
            write_done_reg <= write_done;
        end
    end

endmodule : cache_stage_2

`default_nettype wire

/* verilog/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_params.svh"

module cache_top import cache_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [31:0]                 ufp_addr,
    input  logic [3:0]                  ufp_rmask,
    input  logic [3:0]                  ufp_wmask,
    input  logic [31:0]                 ufp_wdata,
    output logic [31:0]                 ufp_rdata,
    output logic                        ufp_resp,
    output logic [31:0]                 dfp_addr,
    output logic                        dfp_read,
    output logic                        dfp_write,
    output logic [`LINE_BYTES*8-1:0]    dfp_wdata,
    input  logic [`LINE_BYTES*8-1:0]    dfp_rdata,
    input  logic                        dfp_resp
);

    stage_reg_t                 stage_reg, stage_reg_next;
    logic                       read_halt, write_halt, dirty_halt;
    logic                       write_done, write_done_reg;
    logic [2:0]                 lru_read;
    logic                       lru_touch;
    logic [1:0]                 victim_way, hit_way, lru_way;
    logic [`CACHE_WAYS-1:0]     web, valid_in, valid_out;
    logic [`LINE_BYTES-1:0]     data_array_wmask;
    line_u                      data_in [`CACHE_WAYS];
    line_u                      data_out [`CACHE_WAYS];
    tag_entry_t                 tag_in [`CACHE_WAYS];
    tag_entry_t                 tag_out [`CACHE_WAYS];

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_reg <= '0;
        end else begin
            stage_reg <= stage_reg_next;
        end
    end

    assign lru_way = dfp_read ? victim_way : hit_way; // a touch during fetch is the refill

    cache_stage_1 stage_1 (
        .ufp_addr, .ufp_rmask, .ufp_wmask, .ufp_wdata,
        .dfp_rdata, .dfp_resp,
        .read_halt, .write_halt, .dirty_halt,
        .lru_read, .hit_way, .write_done_reg,
        .stage_reg, .stage_reg_next, .write_done,
        .web, .valid_in, .data_in, .tag_in, .data_array_wmask,
        .victim_way
    );

    cache_stage_2 stage_2 (
        .clk, .rst, .stage_reg,
        .data_out, .tag_out, .valid_out, .victim_way, .write_done,
        .ufp_rdata, .ufp_resp,
        .dfp_addr, .dfp_read, .dfp_write, .dfp_wdata, .dfp_resp,
        .read_halt, .write_halt, .dirty_halt, .write_done_reg,
        .hit_way, .lru_touch
    );

    // reads follow the next request so the data lines up with the stage register
    cache_arrays arrays (
        .clk, .rst,
        .rd_set(stage_reg_next.set_no),
        .wr_set(stage_reg.set_no),
        .web, .valid_in, .data_in, .tag_in, .data_array_wmask,
        .data_out, .tag_out, .valid_out
    );

    plru_tree lru (
        .clk, .rst,
        .set_no(stage_reg.set_no),
        .touch(lru_touch),
        .way(lru_way),
        .lru_read
    );

endmodule : cache_top

`default_nettype wire

/* verilog/plru_tree.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cache_params.svh"

module plru_tree (
    input  logic                clk,
    input  logic                rst,
    input  logic [`SET_W-1:0]   set_no,
    input  logic                touch,
    input  logic [1:0]          way,
    output logic [2:0]          lru_read
);

    // bit 0 picks the half, bit 1 picks within ways 0/1, bit 2 within ways 2/3
    logic [2:0] tree [`CACHE_SETS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (touch) begin
            tree[set_no][0] <= way[1]; // point at the other half
            if (way[1]) begin
                tree[set_no][2] <= way[0];
            end else begin
                tree[set_no][1] <= way[0];
            end
        end
    end

    assign lru_read = tree[set_no];

endmodule : plru_tree

`default_nettype wire
